/* hdl/lc4_alu.sv */
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_alu (
  input  lc4_pipe_pkg::stage_t i_stage,
  input  lc4_isa_pkg::word_t   i_a,       // rs after bypass
  input  lc4_isa_pkg::word_t   i_b,       // rt after bypass
  output lc4_isa_pkg::word_t   o_result,
  output lc4_isa_pkg::word_t   o_target
);
  import lc4_isa_pkg::*;

  word_t imm5;
  word_t imm6;
  word_t imm9;

  // Sign-extended immediate fields
  assign imm5 = {{($bits(word_t) - `LC4_IMM5_W){i_stage.insn[`LC4_IMM5_W-1]}},
                 i_stage.insn[`LC4_IMM5_W-1:0]};
  assign imm6 = {{($bits(word_t) - `LC4_IMM6_W){i_stage.insn[`LC4_IMM6_W-1]}},
                 i_stage.insn[`LC4_IMM6_W-1:0]};
  assign imm9 = {{($bits(word_t) - `LC4_IMM9_W){i_stage.insn[`LC4_IMM9_W-1]}},
                 i_stage.insn[`LC4_IMM9_W-1:0]};

  always_comb begin
    case (i_stage.alu_op)
      ALU_ADD:   o_result = i_a + i_b;
      ALU_SUB:   o_result = i_a - i_b;
      ALU_AND:   o_result = i_a & i_b;
      ALU_OR:    o_result = i_a | i_b;
      ALU_XOR:   o_result = i_a ^ i_b;
      ALU_NOT:   o_result = ~i_a;
      ALU_ADDI:  o_result = i_a + imm5;
      ALU_ANDI:  o_result = i_a & imm5;
      ALU_CONST: o_result = imm9;
      ALU_ADDR:  o_result = i_a + imm6;   // Effective address
      default:   o_result = i_a;          // PASS
    endcase
  end

  // BR target, only used when the branch is taken
  assign o_target = i_stage.pc + word_t'(1) + imm9;

endmodule

/* hdl/lc4_cfg.svh */
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// First fetch address out of reset
`define LC4_RESET_PC 16'h8200

// Architectural register file depth
`define LC4_NUM_REGS 8

// Immediate field widths
`define LC4_IMM5_W 5   // ADD/AND immediate, also locates the imm flag bit
`define LC4_IMM6_W 6   // LDR/STR offset
`define LC4_IMM9_W 9   // CONST value and BR offset

`endif

/* hdl/lc4_decoder.sv */
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_decoder (
  input  lc4_isa_pkg::word_t    i_insn,
  output lc4_isa_pkg::reg_idx_t o_rs,
  output lc4_isa_pkg::reg_idx_t o_rt,
  output lc4_isa_pkg::reg_idx_t o_rd,
  output lc4_pipe_pkg::ctrl_t   o_ctrl,
  output lc4_isa_pkg::alu_op_t  o_alu_op
);
  import lc4_isa_pkg::*;

  opcode_t    opcode;
  logic [2:0] sub_op;    // Sub-opcode of register forms
  logic       imm_form;  // Set for ADD/AND immediate

  assign opcode   = opcode_t'(i_insn[15:12]);
  assign sub_op   = i_insn[5:3];
  assign imm_form = i_insn[`LC4_IMM5_W];

  assign o_rs = i_insn[8:6];
  assign o_rt = (opcode == OP_STR) ? i_insn[11:9] : i_insn[2:0];  // STR data reg sits in [11:9]
  assign o_rd = i_insn[11:9];

  always_comb begin
    o_ctrl   = '0;         // Unknown encodings fall through as NOP
    o_alu_op = ALU_PASS;
    case (opcode)
      OP_BR: o_ctrl.is_branch = 1'b1;
      OP_ADD, OP_LOGIC: begin
        if (imm_form) begin
          o_alu_op = (opcode == OP_ADD) ? ALU_ADDI : ALU_ANDI;
        end else if (opcode == OP_ADD) begin
          case (sub_op)
            3'b000:  o_alu_op = ALU_ADD;
            3'b010:  o_alu_op = ALU_SUB;
            default: o_alu_op = ALU_PASS;  // MUL/DIV dropped
          endcase
        end else begin
          case (sub_op)
            3'b000:  o_alu_op = ALU_AND;
            3'b001:  o_alu_op = ALU_NOT;
            3'b010:  o_alu_op = ALU_OR;
            3'b011:  o_alu_op = ALU_XOR;
            default: o_alu_op = ALU_PASS;
          endcase
        end
        if (o_alu_op != ALU_PASS) begin
          o_ctrl.rs_re      = 1'b1;
          o_ctrl.rt_re      = !imm_form && (o_alu_op != ALU_NOT);  // NOT reads rs only
          o_ctrl.regfile_we = 1'b1;
          o_ctrl.nzp_we     = 1'b1;
        end
      end
      OP_LDR: begin
        o_ctrl.rs_re      = 1'b1;
        o_ctrl.regfile_we = 1'b1;
        o_ctrl.nzp_we     = 1'b1;
        o_ctrl.is_load    = 1'b1;
        o_alu_op          = ALU_ADDR;
      end
      OP_STR: begin
        o_ctrl.rs_re    = 1'b1;  // Base
        o_ctrl.rt_re    = 1'b1;  // Data
        o_ctrl.is_store = 1'b1;
        o_alu_op        = ALU_ADDR;
      end
      OP_CONST: begin
        o_ctrl.regfile_we = 1'b1;
        o_ctrl.nzp_we     = 1'b1;
        o_alu_op          = ALU_CONST;
      end
      default: ;
    endcase
  end

  // A word is never treated as both a load and a store downstream
  always_comb begin
    assert final (!(o_ctrl.is_load && o_ctrl.is_store))
      else $error("Decoder set load and store together for %h", i_insn);
  end

endmodule

/* hdl/lc4_hazard.sv */
`timescale 1ns/1ps

module lc4_hazard (
  input  lc4_pipe_pkg::stage_t i_d,
  input  lc4_pipe_pkg::stage_t i_x,
  input  lc4_pipe_pkg::stage_t i_m,
  input  lc4_pipe_pkg::stage_t i_w,
  input  lc4_isa_pkg::word_t   i_w_value,     // Writeback result
  input  lc4_isa_pkg::nzp_t    i_nzp,         // Architectural NZP register
  output logic                 o_stall,
  output logic                 o_flush,
  output logic                 o_fwd_a,       // Use W value for M rs
  output logic                 o_fwd_b,       // Use W value for M rt
  output lc4_isa_pkg::nzp_t    o_branch_nzp
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic w_fwd_ok;  // W result is available for bypass
  nzp_t w_nzp;

  // True when stage s reads register r
  function automatic logic reads_reg(stage_t s, reg_idx_t r);
    return (s.ctrl.rs_re && (s.rs == r)) || (s.ctrl.rt_re && (s.rt == r));
  endfunction

  assign o_stall = i_x.valid && i_x.ctrl.is_load && reads_reg(i_d, i_x.rd);  // Load-use

  assign w_fwd_ok = i_w.valid && i_w.ctrl.regfile_we && !i_w.ctrl.is_load;
  assign o_fwd_a  = w_fwd_ok && i_m.ctrl.rs_re && (i_w.rd == i_m.rs);
  assign o_fwd_b  = w_fwd_ok && i_m.ctrl.rt_re && (i_w.rd == i_m.rt);

  // NZP of the value being written back
  assign w_nzp = {i_w_value[15], i_w_value == '0, !i_w_value[15] && (i_w_value != '0)};
  assign o_branch_nzp = (i_w.valid && i_w.ctrl.nzp_we) ? w_nzp : i_nzp;

  assign o_flush = i_m.valid && i_m.ctrl.is_branch && |(i_m.insn[11:9] & o_branch_nzp);

  // Load-use bubble keeps a dependent out of M while its load sits in W
  always_comb begin
    if (i_w.valid && i_w.ctrl.is_load) begin
      assert final (!reads_reg(i_m, i_w.rd))
        else $error("Load at %h feeds M at %h with no bypass", i_w.pc, i_m.pc);
    end
  end

endmodule

/* hdl/lc4_isa_pkg.sv */
package lc4_isa_pkg;

  typedef logic [15:0] word_t;     // Machine word, also a memory address
  typedef logic [2:0]  reg_idx_t;  // R0..R7
  typedef logic [2:0]  nzp_t;      // [2] negative, [1] zero, [0] positive

  // Major opcodes kept in this core, everything else decodes as NOP
  typedef enum logic [3:0] {
    OP_BR    = 4'b0000,
    OP_ADD   = 4'b0001,  // ADD/SUB (MUL/DIV not supported)
    OP_LOGIC = 4'b0101,  // AND/NOT/OR/XOR
    OP_LDR   = 4'b0110,
    OP_STR   = 4'b0111,
    OP_CONST = 4'b1001
  } opcode_t;

  // Operation applied by the ALU in the Memory stage
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT,
    ALU_ADDI,
    ALU_ANDI,
    ALU_CONST,
    ALU_ADDR,  // Base plus imm6 for LDR/STR
    ALU_PASS   // Branches and NOPs
  } alu_op_t;

endpackage

/* hdl/lc4_pipe_pkg.sv */
package lc4_pipe_pkg;
  import lc4_isa_pkg::*;

  // Per-instruction control bits from the decoder, all zero for a bubble
  typedef struct packed {
    logic rs_re;
    logic rt_re;
    logic regfile_we;
    logic nzp_we;
    logic is_load;
    logic is_store;
    logic is_branch;
  } ctrl_t;

  // Instruction record handed from stage to stage
  typedef struct packed {
    logic     valid;   // 0 marks a bubble
    word_t    pc;
    word_t    insn;
    reg_idx_t rs;
    reg_idx_t rt;      // Data register for STR
    reg_idx_t rd;
    ctrl_t    ctrl;
    alu_op_t  alu_op;
  } stage_t;

  // Data memory request from the Memory stage
  typedef struct packed {
    logic  we;
    word_t addr;   // 0 for non-memory instructions
    word_t wdata;
  } dmem_req_t;

  // What a retiring instruction did, seen at Writeback
  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    logic     regfile_we;
    reg_idx_t wsel;
    word_t    wdata;
    logic     nzp_we;
    nzp_t     nzp;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_data;  // Stored value or loaded value
  } retire_t;

  // Reason for a non-valid retire slot
  typedef enum logic [1:0] {
    STALL_NONE  = 2'b00,
    STALL_FLUSH = 2'b10,  // Taken branch or reset bubble
    STALL_LOAD  = 2'b11   // Load-use bubble
  } stall_t;

endpackage

/* hdl/lc4_processor.sv */
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_processor (
  input  logic                    gwe,
  input  logic                    i_rst_n,
  output lc4_isa_pkg::word_t      o_imem_addr,
  input  lc4_isa_pkg::word_t      i_imem_data,
  output lc4_pipe_pkg::dmem_req_t o_dmem,
  input  lc4_isa_pkg::word_t      i_dmem_rdata,  // Valid in the load's Writeback cycle
  output lc4_pipe_pkg::retire_t   o_retire,
  output lc4_pipe_pkg::stall_t    o_stall
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  word_t     pc_q;
  stage_t    d_stage;             // Decode, straight off the fetch bus
  stage_t    x_q, m_q, w_q;       // Execute, Memory, Writeback records
  stall_t    x_stall_q, m_stall_q, w_stall_q;
  word_t     m_a_q, m_b_q;        // Operands read in Execute
  word_t     w_result_q;
  dmem_req_t w_dmem_q;            // Memory request seen by the W instruction
  nzp_t      nzp_q, branch_nzp;
  reg_idx_t  d_rs, d_rt, d_rd;
  ctrl_t     d_ctrl;
  alu_op_t   d_alu_op;
  word_t     rs_data, rt_data;
  word_t     alu_a, alu_b, alu_result, alu_target;
  word_t     w_value;
  logic      stall, flush, fwd_a, fwd_b;

  lc4_decoder u_decoder (
    .i_insn   (i_imem_data),
    .o_rs     (d_rs),
    .o_rt     (d_rt),
    .o_rd     (d_rd),
    .o_ctrl   (d_ctrl),
    .o_alu_op (d_alu_op)
  );

  always_comb begin
    d_stage.valid  = 1'b1;
    d_stage.pc     = pc_q;
    d_stage.insn   = i_imem_data;
    d_stage.rs     = d_rs;
    d_stage.rt     = d_rt;
    d_stage.rd     = d_rd;
    d_stage.ctrl   = d_ctrl;
    d_stage.alu_op = d_alu_op;
  end

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs      (x_q.rs),
    .i_rt      (x_q.rt),
    .i_rd      (w_q.rd),
    .i_we      (w_q.ctrl.regfile_we),
    .i_wdata   (w_value),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  lc4_hazard u_hazard (
    .i_d          (d_stage),
    .i_x          (x_q),
    .i_m          (m_q),
    .i_w          (w_q),
    .i_w_value    (w_value),
    .i_nzp        (nzp_q),
    .o_stall      (stall),
    .o_flush      (flush),
    .o_fwd_a      (fwd_a),
    .o_fwd_b      (fwd_b),
    .o_branch_nzp (branch_nzp)
  );

  assign alu_a = fwd_a ? w_value : m_a_q;  // W to M bypass
  assign alu_b = fwd_b ? w_value : m_b_q;

  lc4_alu u_alu (
    .i_stage  (m_q),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_target (alu_target)
  );

  // Control state: PC, stage records, stall codes, NZP
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      pc_q      <= `LC4_RESET_PC;
      x_q       <= '0;
      m_q       <= '0;
      w_q       <= '0;
      x_stall_q <= STALL_FLUSH;  // Reset bubbles report as flush
      m_stall_q <= STALL_FLUSH;
      w_stall_q <= STALL_FLUSH;
      nzp_q     <= '0;
    end else begin
      if (flush) begin
        pc_q <= alu_target;
      end else if (!stall) begin
        pc_q <= pc_q + word_t'(1);
      end
      x_q       <= (flush || stall) ? '0 : d_stage;       // Bubble into X
      x_stall_q <= flush ? STALL_FLUSH : (stall ? STALL_LOAD : STALL_NONE);
      m_q       <= flush ? '0 : x_q;                      // Second flush bubble
      m_stall_q <= flush ? STALL_FLUSH : x_stall_q;
      w_q       <= m_q;
      w_stall_q <= m_stall_q;
      nzp_q     <= branch_nzp;   // Holds unless W writes NZP
    end
  end

  // Datapath values ride along with the records
  always_ff @(posedge gwe) begin
    m_a_q      <= rs_data;
    m_b_q      <= rt_data;
    w_result_q <= alu_result;
    w_dmem_q   <= o_dmem;
  end

  assign o_imem_addr = pc_q;

  assign o_dmem.we    = m_q.ctrl.is_store;
  assign o_dmem.addr  = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? alu_result : '0;
  assign o_dmem.wdata = m_q.ctrl.is_store ? alu_b : '0;

  assign w_value = w_q.ctrl.is_load ? i_dmem_rdata : w_result_q;

  always_comb begin
    o_retire.valid      = w_q.valid;
    o_retire.pc         = w_q.pc;
    o_retire.insn       = w_q.insn;
    o_retire.regfile_we = w_q.ctrl.regfile_we;
    o_retire.wsel       = w_q.rd;
    o_retire.wdata      = w_value;
    o_retire.nzp_we     = w_q.ctrl.nzp_we;
    o_retire.nzp        = branch_nzp;             // W's own bits when it writes NZP
    o_retire.dmem_we    = w_q.ctrl.is_store;
    o_retire.dmem_addr  = w_dmem_q.addr;
    o_retire.dmem_data  = w_q.ctrl.is_load ? i_dmem_rdata : w_dmem_q.wdata;
  end

  assign o_stall = w_stall_q;

  dmem_we_store_a: assert property (@(posedge gwe) disable iff (!i_rst_n)
    o_dmem.we |-> (m_q.valid && m_q.ctrl.is_store))
    else $error("Data memory write without a store in M at %h", m_q.pc);

endmodule

/* hdl/lc4_regfile.sv */
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_regfile (
  input  logic                  gwe,
  input  logic                  i_rst_n,
  input  lc4_isa_pkg::reg_idx_t i_rs,
  input  lc4_isa_pkg::reg_idx_t i_rt,
  input  lc4_isa_pkg::reg_idx_t i_rd,
  input  logic                  i_we,
  input  lc4_isa_pkg::word_t    i_wdata,
  output lc4_isa_pkg::word_t    o_rs_data,
  output lc4_isa_pkg::word_t    o_rt_data
);
  import lc4_isa_pkg::*;

  word_t regs_q [`LC4_NUM_REGS];

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `LC4_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_we) begin
      regs_q[i_rd] <= i_wdata;
    end
  end

  // Write-through so Execute sees this cycle's Writeback value
  assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs_q[i_rs];
  assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs_q[i_rt];

  wdata_known_a: assert property (@(posedge gwe) disable iff (!i_rst_n)
    i_we |-> !$isunknown(i_wdata)) else $error("Regfile write of unknown data to R%0d", i_rd);

endmodule

/* list.f */
+incdir+hdl
hdl/lc4_isa_pkg.sv
hdl/lc4_pipe_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_alu.sv
hdl/lc4_regfile.sv
hdl/lc4_hazard.sv
hdl/lc4_processor.sv
tb/tb_clk_gen.sv
tb/lc4_processor_tb.sv

/* tb/lc4_processor_tb.sv */
`timescale 1ns/1ps
`include "lc4_cfg.svh"

module lc4_processor_tb;
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  localparam int PROG_LEN    = 200;
  localparam int CYCLE_LIMIT = 16 + 3 * PROG_LEN + 50;
  localparam word_t END_PC   = `LC4_RESET_PC + PROG_LEN;

  logic      gwe, rst_n;
  word_t     imem_addr, imem_data, dmem_rdata = '0;
  dmem_req_t dmem_req;
  retire_t   retire;
  stall_t    stall_code;

  word_t imem [256];
  word_t dmem [256];                // Memory seen by the DUT
  word_t mmem [256];                // Model copy
  word_t mregs [`LC4_NUM_REGS];
  nzp_t  mnzp = '0;
  word_t model_pc = `LC4_RESET_PC;
  logic  seen_retire = 1'b0;
  int    cycles = 0;
  int    prog_pos;
  int    hits [1:6];
  int    errors [1:6];
  string names [1:6] = '{"reset and first retire", "pc sequence", "alu and const results",
                         "load-use stall", "taken branch flush", "store and load"};

  // Expected effect of the instruction at model_pc
  word_t    m_insn, va, vb, e_val, e_addr, e_mdata, e_next;
  reg_idx_t e_rd;
  logic     e_we, e_load, e_store, e_branch, e_taken, e_dep;

  tb_clk_gen u_clk_gen (.o_gwe(gwe), .o_rst_n(rst_n));

  lc4_processor dut (
    .gwe          (gwe),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem       (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_retire     (retire),
    .o_stall      (stall_code)
  );

  function automatic word_t imem_word(word_t pc);
    word_t off;
    off = pc - `LC4_RESET_PC;
    return (off < 256) ? imem[off[7:0]] : 16'h0000;  // Outside the program reads as NOP
  endfunction

  function automatic word_t sext(word_t v, int w);
    return word_t'($signed(v << (16 - w)) >>> (16 - w));
  endfunction

  function automatic nzp_t nzp_of(word_t v);
    return {v[15], v == '0, !v[15] && (v != '0)};
  endfunction

  // Register reads of an instruction, per the ISA
  function automatic logic reads_reg(word_t w, reg_idx_t r);
    case (w[15:12])
      4'b0001, 4'b0101: return (w[8:6] == r) || (!w[5] && (w[5:3] != 3'b001 || w[15:12] == 4'b0001)
                               && w[2:0] == r);
      4'b0110: return w[8:6] == r;
      4'b0111: return (w[8:6] == r) || (w[11:9] == r);  // Base and data
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t rand_alu_insn();
    logic [2:0] d, s, t;
    logic [4:0] imm5;
    d = 3'($urandom);
    s = 3'($urandom);
    t = 3'($urandom);
    imm5 = 5'($urandom);
    case ($urandom_range(8, 0))
      0: return {4'b0001, d, s, 3'b000, t};          // ADD
      1: return {4'b0001, d, s, 3'b010, t};          // SUB
      2: return {4'b0101, d, s, 3'b000, t};          // AND
      3: return {4'b0101, d, s, 3'b001, t};          // NOT
      4: return {4'b0101, d, s, 3'b010, t};          // OR
      5: return {4'b0101, d, s, 3'b011, t};          // XOR
      6: return {4'b0001, d, s, 1'b1, imm5};         // ADD imm
      7: return {4'b0101, d, s, 1'b1, imm5};         // AND imm
      default: return {4'b1001, d, 9'($urandom)};    // CONST
    endcase
  endfunction

  task automatic emit(word_t w);
    imem[prog_pos] = w;
    prog_pos++;
  endtask

  task automatic build_program();
    int         kind;
    int         skip;
    logic [2:0] r1, r2, r3, bit_nzp;
    logic [5:0] off;
    logic [8:0] imm9;
    prog_pos = 0;
    emit({4'b1001, 3'd1, 9'h0a5});  // Two CONSTs so no store reaches M before the first retire
    emit({4'b1001, 3'd2, 9'h13c});
    while (prog_pos < PROG_LEN - 12) begin
      kind = $urandom_range(9, 0);
      r1 = 3'($urandom);
      r2 = 3'($urandom);
      r3 = 3'($urandom);
      off = 6'($urandom);
      case (kind)
        6: begin
          emit({4'b0111, r1, r2, off});  // Store, then load back from the same address
          emit({4'b0110, r3, r2, off});
        end
        7: begin
          emit({4'b0110, r3, r2, off});
          emit({4'b0001, r1, r3, 3'b000, r2});  // Uses the load result right away
        end
        8, 9: begin
          imm9 = 9'($urandom);
          bit_nzp = imm9[8] ? 3'b100 : ((imm9 == '0) ? 3'b010 : 3'b001);
          skip = $urandom_range(3, 1);
          emit({4'b1001, r1, imm9});    // Sets a known NZP
          emit({4'b0000, (kind == 8) ? (bit_nzp | 3'($urandom)) : ~bit_nzp, 9'(skip)});
          for (int i = 0; i < skip; i++) emit(rand_alu_insn());  // Skipped when taken
        end
        default: emit(rand_alu_insn());
      endcase
    end
    while (prog_pos < PROG_LEN) emit(rand_alu_insn());
  endtask

  task automatic count_failure(int id, string msg);
    $display("%s", msg);
    errors[id]++;
  endtask

  assign imem_data = imem_word(imem_addr);  // Combinational fetch

  // Synchronous data memory, read registered every edge
  always @(posedge gwe) begin
    if (dmem_req.we) dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
    dmem_rdata <= dmem[dmem_req.addr[7:0]];
  end

  // Architectural model
  always_comb begin
    m_insn   = imem_word(model_pc);
    va       = mregs[m_insn[8:6]];
    vb       = mregs[m_insn[2:0]];
    e_rd     = m_insn[11:9];
    e_we     = 1'b0;
    e_load   = 1'b0;
    e_store  = 1'b0;
    e_branch = 1'b0;
    e_taken  = 1'b0;
    e_val    = '0;
    e_addr   = '0;
    e_mdata  = '0;
    e_next   = model_pc + 16'd1;
    case (m_insn[15:12])
      4'b0001: begin
        e_we = 1'b1;
        if (m_insn[5]) e_val = va + sext(m_insn, `LC4_IMM5_W);
        else if (m_insn[5:3] == 3'b010) e_val = va - vb;
        else e_val = va + vb;
      end
      4'b0101: begin
        e_we = 1'b1;
        if (m_insn[5]) e_val = va & sext(m_insn, `LC4_IMM5_W);
        else if (m_insn[4:3] == 2'b00) e_val = va & vb;
        else if (m_insn[4:3] == 2'b01) e_val = ~va;
        else if (m_insn[4:3] == 2'b10) e_val = va | vb;
        else e_val = va ^ vb;
      end
      4'b0110: begin
        e_we    = 1'b1;
        e_load  = 1'b1;
        e_addr  = va + sext(m_insn, `LC4_IMM6_W);
        e_mdata = mmem[e_addr[7:0]];
        e_val   = e_mdata;
      end
      4'b0111: begin
        e_store = 1'b1;
        e_addr  = va + sext(m_insn, `LC4_IMM6_W);
        e_mdata = mregs[m_insn[11:9]];
      end
      4'b1001: begin
        e_we  = 1'b1;
        e_val = sext(m_insn, `LC4_IMM9_W);
      end
      4'b0000: begin
        e_branch = 1'b1;
        e_taken  = |(m_insn[11:9] & mnzp);
        if (e_taken) e_next = model_pc + 16'd1 + sext(m_insn, `LC4_IMM9_W);
      end
      default: ;
    endcase
    e_dep = e_load && reads_reg(imem_word(model_pc + 16'd1), e_rd);
  end

  always @(posedge gwe) begin
    cycles <= cycles + 1;
    if (rst_n && retire.valid) begin
      seen_retire <= 1'b1;
      model_pc    <= e_next;
      if (e_we) mregs[e_rd] <= e_val;
      if (e_we) mnzp <= nzp_of(e_val);
      if (e_store) mmem[e_addr[7:0]] <= e_mdata;
      hits[1]++;
      if (e_branch) hits[2]++;
      if (e_we && !e_load) hits[3]++;
      if (e_dep) hits[4]++;
      if (e_taken) hits[5]++;
      if (e_store) hits[6]++;
    end
  end

  reset_quiet_a: assert property (@(posedge gwe)
    (cycles > 0 && !rst_n) |-> !retire.valid && !dmem_req.we)
    else count_failure(1, "Retire or memory write seen while reset was held");
  first_quiet_a: assert property (@(posedge gwe) disable iff (!rst_n)
    !seen_retire |-> !dmem_req.we)
    else count_failure(1, "Data memory written before the first retire");
  insn_a: assert property (@(posedge gwe) disable iff (!rst_n)
    retire.valid |-> retire.insn == m_insn)
    else count_failure(1, $sformatf("ERROR %0t: insn %h at pc %h differs from memory",
                                    $time, $sampled(retire.insn), $sampled(retire.pc)));
  pc_a: assert property (@(posedge gwe) disable iff (!rst_n)
    retire.valid |-> retire.pc == model_pc)
    else count_failure(2, $sformatf("ERROR %0t: retired pc %h, expected %h",
                                    $time, $sampled(retire.pc), $sampled(model_pc)));
  no_bubble_a: assert property (@(posedge gwe) disable iff (!rst_n)
    (retire.valid && !e_taken && !e_dep) |=> retire.valid)
    else count_failure(2, "Unexpected bubble after an instruction with no hazard");
  regwrite_a: assert property (@(posedge gwe) disable iff (!rst_n)
    retire.valid |-> retire.regfile_we == e_we
                     && (!e_we || (retire.wsel == e_rd && retire.wdata == e_val)))
    else count_failure(3, $sformatf("ERROR %0t: pc %h wrote R%0d=%h, expected R%0d=%h",
                                    $time, $sampled(retire.pc), $sampled(retire.wsel),
                                    $sampled(retire.wdata), $sampled(e_rd), $sampled(e_val)));
  nzp_a: assert property (@(posedge gwe) disable iff (!rst_n)
    retire.valid |-> retire.nzp_we == e_we
                     && (!e_we || retire.nzp == nzp_of(e_val)))
    else count_failure(3, $sformatf("ERROR %0t: pc %h nzp %b, expected %b",
                                    $time, $sampled(retire.pc), $sampled(retire.nzp),
                                    nzp_of($sampled(e_val))));
  load_use_a: assert property (@(posedge gwe) disable iff (!rst_n)
    (retire.valid && e_dep) |=> (!retire.valid && stall_code == STALL_LOAD) ##1 retire.valid)
    else count_failure(4, "Load-use did not give exactly one LOAD bubble");
  flush_a: assert property (@(posedge gwe) disable iff (!rst_n)
    (retire.valid && e_taken) |=> (!retire.valid && stall_code == STALL_FLUSH)
                                  ##1 (!retire.valid && stall_code == STALL_FLUSH)
                                  ##1 retire.valid)
    else count_failure(5, "Taken branch did not give exactly two FLUSH bubbles");
  mem_a: assert property (@(posedge gwe) disable iff (!rst_n)
    retire.valid |-> retire.dmem_we == e_store && (!(e_store || e_load)
                     || (retire.dmem_addr == e_addr && retire.dmem_data == e_mdata)))
    else count_failure(6, $sformatf("ERROR %0t: pc %h memory %h=%h, expected %h=%h",
                                    $time, $sampled(retire.pc), $sampled(retire.dmem_addr),
                                    $sampled(retire.dmem_data), $sampled(e_addr),
                                    $sampled(e_mdata)));

  initial begin
    int failed;
    int total;
    void'($urandom(32'h05af85ae));
    for (int i = 0; i < 256; i++) begin
      imem[i] = 16'h0000;
      dmem[i] = word_t'(i * 16'h9e37) ^ word_t'(i << 8) ^ 16'h5a3c;  // Varies with all address bits
      mmem[i] = dmem[i];
    end
    for (int i = 0; i < `LC4_NUM_REGS; i++) mregs[i] = '0;
    build_program();
    while (model_pc < END_PC && cycles < CYCLE_LIMIT) @(posedge gwe);
    if (model_pc < END_PC) begin
      $display("Timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
    end else begin
      repeat (4) @(posedge gwe);  // Let pending bubble checks complete
      failed = 0;
      total  = 0;
      for (int b = 1; b <= 6; b++) begin
        if (hits[b] == 0) $display("Behavior '%s' was never exercised", names[b]);
        if (hits[b] == 0 || errors[b] != 0) failed++;
        total += errors[b];
        $display("%-24s %0d hits, %0d errors, %s", names[b], hits[b], errors[b],
                 (hits[b] != 0 && errors[b] == 0) ? "ok" : "failed");
      end
      $display("Tests 6, failed %0d, errors %0d", failed, total);
      if (failed == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_gwe,
  output logic o_rst_n
);
  int unsigned edges = 0;

  initial o_gwe = 1'b0;
  always #10 o_gwe = ~o_gwe;  // 20 ns period

  initial o_rst_n = 1'b0;
  always @(posedge o_gwe) begin
    edges <= edges + 1;
    if (edges == 15) o_rst_n <= 1'b1;  // Low for the first 16 rising edges
  end

endmodule
